// File: verilog/timer_pkg.sv
// Shared definitions for the machine timer
// Bus and register widths, register offsets
// Bus command, width and response codes
// Request, response, write strobe and config structs
// Control word union
package timer_pkg;

    // ----------------------------------------
    // Sizes
    // ----------------------------------------
    localparam int unsigned dmem_awidth      = 32;
    localparam int unsigned dmem_dwidth      = 32;
    // Low address bits decoded by the slave
    localparam int unsigned timer_addr_width = 5;
    localparam int unsigned divider_width    = 10;

    // ----------------------------------------
    // Register offsets
    // ----------------------------------------
    localparam logic [timer_addr_width-1:0] addr_control  = 5'h00;
    localparam logic [timer_addr_width-1:0] addr_divider  = 5'h04;
    localparam logic [timer_addr_width-1:0] addr_mtime_lo = 5'h08;
    localparam logic [timer_addr_width-1:0] addr_mtime_hi = 5'h0C;
    localparam logic [timer_addr_width-1:0] addr_cmp_lo   = 5'h10;
    localparam logic [timer_addr_width-1:0] addr_cmp_hi   = 5'h14;
    // Highest valid offset, anything above answers with error
    localparam logic [timer_addr_width-1:0] addr_last     = addr_cmp_hi;

    // ----------------------------------------
    // Bus codes
    // ----------------------------------------
    typedef enum logic {
        mem_cmd_rd = 1'b0,
        mem_cmd_wr = 1'b1
    } mem_cmd_e;

    typedef enum logic [1:0] {
        mem_width_byte = 2'd0,
        mem_width_half = 2'd1,
        mem_width_word = 2'd2
    } mem_width_e;

    typedef enum logic [1:0] {
        mem_resp_notrdy = 2'd0,
        mem_resp_ok     = 2'd1,
        mem_resp_err    = 2'd2
    } mem_resp_e;

    // ----------------------------------------
    // Structs
    // ----------------------------------------
    // Master side of the data memory port
    typedef struct packed {
        logic                   req;
        mem_cmd_e               cmd;
        mem_width_e             width;
        logic [dmem_awidth-1:0] addr;
        logic [dmem_dwidth-1:0] wdata;
    } bus_req_t;

    // Slave side of the data memory port
    typedef struct packed {
        logic                   req_ack;
        logic [dmem_dwidth-1:0] rdata;
        mem_resp_e              resp;
    } bus_rsp_t;

    // One-hot write strobes plus the word to write
    typedef struct packed {
        logic                   control;
        logic                   divider;
        logic                   mtime_lo;
        logic                   mtime_hi;
        logic                   cmp_lo;
        logic                   cmp_hi;
        logic [dmem_dwidth-1:0] wdata;
    } reg_wr_t;

    // Prescaler settings
    typedef struct packed {
        logic                     en;
        logic [divider_width-1:0] div;
    } timer_cfg_t;

    // Control register layout, bit 1 was the RTC source select
    typedef struct packed {
        logic [dmem_dwidth-3:0] rsvd_hi;
        logic                   rsvd_clksrc;
        logic                   en;
    } ctrl_fields_t;

    // Control word seen as raw data or as fields
    typedef union packed {
        logic [dmem_dwidth-1:0] raw;
        ctrl_fields_t           fields;
    } ctrl_word_u;

endpackage

// File: verilog/timer_bus_slave.sv
// Data memory slave port of the timer
// Input register, acceptance and request check
// Write strobe decode
// Registered response and read data mux
module timer_bus_slave
    import timer_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    input  bus_req_t        bus_req,
    input  logic [63:0]     mtime,
    input  logic [63:0]     mtimecmp,
    input  timer_cfg_t      cfg,
    output bus_rsp_t        bus_rsp,
    output reg_wr_t         reg_wr
);

    // Input stage
    logic                          req_q;
    bus_req_t                      req_pl;
    logic                          req_ok;

    // Acceptance stage
    logic                          ack_q;
    logic                          acc_q;
    logic                          valid_q;
    mem_cmd_e                      cmd_q;
    logic [timer_addr_width-1:0]   offs_q;
    logic [dmem_dwidth-1:0]        wdata_q;

    // Response stage
    mem_resp_e                     resp_q;
    logic [dmem_dwidth-1:0]        rdata_q;
    logic [dmem_dwidth-1:0]        rd_mux;

    // ----------------------------------------
    // Input register
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            req_q <= 1'b0;
        end else begin
            req_q <= bus_req.req;
        end
    end

    // Payload, qualified by req_q
    always_ff @(posedge clk) begin
        req_pl <= bus_req;
    end

    // Word access, aligned, inside the register map
    assign req_ok = (req_pl.width == mem_width_word) &&
                    (req_pl.addr[1:0] == 2'b00) &&
                    (req_pl.addr[timer_addr_width-1:0] <= addr_last);

    // ----------------------------------------
    // Acceptance
    // ----------------------------------------
    // Ack is a single pulse, a held request is not taken twice
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q   <= 1'b0;
            acc_q   <= 1'b0;
            valid_q <= 1'b0;
            cmd_q   <= mem_cmd_rd;
            offs_q  <= '0;
        end else begin
            ack_q   <= req_q & ~ack_q;
            acc_q   <= req_q & ~ack_q;
            valid_q <= req_q & ~ack_q & req_ok;
            cmd_q   <= req_pl.cmd;
            offs_q  <= req_pl.addr[timer_addr_width-1:0];
        end
    end

    always_ff @(posedge clk) begin
        wdata_q <= req_pl.wdata;
    end

    // ----------------------------------------
    // Write strobes
    // ----------------------------------------
    always_comb begin
        reg_wr       = '0;
        reg_wr.wdata = wdata_q;
        if (valid_q && (cmd_q == mem_cmd_wr)) begin
            case (offs_q)
                addr_control:  reg_wr.control  = 1'b1;
                addr_divider:  reg_wr.divider  = 1'b1;
                addr_mtime_lo: reg_wr.mtime_lo = 1'b1;
                addr_mtime_hi: reg_wr.mtime_hi = 1'b1;
                addr_cmp_lo:   reg_wr.cmp_lo   = 1'b1;
                addr_cmp_hi:   reg_wr.cmp_hi   = 1'b1;
                default: begin
                end
            endcase
        end
    end

    // ----------------------------------------
    // Read mux and response
    // ----------------------------------------
    always_comb begin
        ctrl_word_u ctrl;
        ctrl           = '0;
        ctrl.fields.en = cfg.en;
        case (offs_q)
            addr_control:  rd_mux = ctrl.raw;
            addr_divider:  rd_mux = dmem_dwidth'(cfg.div);
            addr_mtime_lo: rd_mux = mtime[31:0];
            addr_mtime_hi: rd_mux = mtime[63:32];
            addr_cmp_lo:   rd_mux = mtimecmp[31:0];
            addr_cmp_hi:   rd_mux = mtimecmp[63:32];
            default:       rd_mux = '0;
        endcase
    end

    // Every accepted request gets ok or error, never left hanging
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resp_q  <= mem_resp_notrdy;
            rdata_q <= '0;
        end else if (!acc_q) begin
            resp_q  <= mem_resp_notrdy;
            rdata_q <= '0;
        end else if (!valid_q) begin
            resp_q  <= mem_resp_err;
            rdata_q <= '0;
        end else begin
            resp_q  <= mem_resp_ok;
            // Writes return zero data
            rdata_q <= (cmd_q == mem_cmd_rd) ? rd_mux : '0;
        end
    end

    assign bus_rsp = '{req_ack: ack_q, rdata: rdata_q, resp: resp_q};

endmodule

// File: verilog/timer_prescaler.sv
// Timer prescaler
// Control enable and divider registers
// Down-counter producing the time tick
module timer_prescaler
    import timer_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  reg_wr_t     reg_wr,
    output timer_cfg_t  cfg,
    output logic        tick
);

    logic                       en_q;
    logic [divider_width-1:0]   div_q;
    logic [divider_width-1:0]   cnt;
    ctrl_word_u                 ctrl_wr;

    // Write word seen as control fields
    assign ctrl_wr.raw = reg_wr.wdata;

    // ----------------------------------------
    // Control and divider registers
    // ----------------------------------------
    // Timer runs out of reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            en_q  <= 1'b1;
            div_q <= '0;
        end else begin
            if (reg_wr.control) begin
                en_q <= ctrl_wr.fields.en;
            end
            if (reg_wr.divider) begin
                div_q <= reg_wr.wdata[divider_width-1:0];
            end
        end
    end

    // ----------------------------------------
    // Down-counter
    // ----------------------------------------
    // One tick every div+1 cycles while enabled
    assign tick = en_q & (cnt == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (reg_wr.divider) begin
            // New divider restarts the count at once
            cnt <= reg_wr.wdata[divider_width-1:0];
        end else if (tick) begin
            cnt <= div_q;
        end else if (en_q) begin
            cnt <= cnt - 1'b1;
        end
    end

    assign cfg = '{en: en_q, div: div_q};

endmodule

// File: verilog/timer_mtime.sv
// 64-bit machine time register
// Split 32-bit increment with registered carry flag
// Low and high word write path
module timer_mtime
    import timer_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  reg_wr_t      reg_wr,
    input  logic         tick,
    output logic [63:0]  mtime
);

    logic [63:0]  mtime_q;
    logic [63:0]  mtime_new;
    logic         lo_ones_q;
    logic         upd;

    // ----------------------------------------
    // Next value
    // ----------------------------------------
    // Tick wins over a bus write in the same cycle
    always_comb begin
        mtime_new = mtime_q;
        if (tick) begin
            mtime_new[31:0] = mtime_q[31:0] + 32'd1;
            // Carry taken from the flag, no 64-bit adder
            if (lo_ones_q) begin
                mtime_new[63:32] = mtime_q[63:32] + 32'd1;
            end
        end else if (reg_wr.mtime_lo) begin
            mtime_new[31:0] = reg_wr.wdata;
        end else if (reg_wr.mtime_hi) begin
            mtime_new[63:32] = reg_wr.wdata;
        end
    end

    assign upd = tick | reg_wr.mtime_lo | reg_wr.mtime_hi;

    // ----------------------------------------
    // Register and carry flag
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtime_q   <= '0;
            lo_ones_q <= 1'b0;
        end else if (upd) begin
            mtime_q   <= mtime_new;
            // Low word all ones means next tick carries
            lo_ones_q <= &mtime_new[31:0];
        end
    end

    assign mtime = mtime_q;

endmodule

// File: verilog/timer_compare.sv
// Timer compare register
// 64-bit compare value with half-word writes
// Sticky level interrupt
module timer_compare
    import timer_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  reg_wr_t      reg_wr,
    input  logic [63:0]  mtime,
    output logic [63:0]  mtimecmp,
    output logic         timer_irq
);

    logic [63:0]  cmp_q;
    logic [63:0]  cmp_new;
    logic         cmp_wr;
    logic         cmp_hit;
    logic         irq_q;

    // ----------------------------------------
    // Compare register
    // ----------------------------------------
    assign cmp_wr = reg_wr.cmp_lo | reg_wr.cmp_hi;

    always_comb begin
        cmp_new = cmp_q;
        if (reg_wr.cmp_lo) begin
            cmp_new[31:0] = reg_wr.wdata;
        end
        if (reg_wr.cmp_hi) begin
            cmp_new[63:32] = reg_wr.wdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmp_q <= '0;
        end else if (cmp_wr) begin
            cmp_q <= cmp_new;
        end
    end

    // ----------------------------------------
    // Interrupt
    // ----------------------------------------
    // Compare against the value being written, if any
    assign cmp_hit = (mtime >= (cmp_wr ? cmp_new : cmp_q));

    // Set on a hit, cleared only by a compare write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq_q <= 1'b0;
        end else if (!irq_q || cmp_wr) begin
            irq_q <= cmp_hit;
        end
    end

    assign mtimecmp  = cmp_q;
    assign timer_irq = irq_q;

endmodule

// File: verilog/timer_top.sv
// Machine timer top level
// Bus slave, prescaler, time register and compare block
module timer_top
    import timer_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  bus_req_t     bus_req,
    output bus_rsp_t     bus_rsp,
    output logic [63:0]  timer_val,
    output logic         timer_irq
);

    // Write strobes to all register blocks
    reg_wr_t      reg_wr;
    timer_cfg_t   cfg;
    logic         tick;
    logic [63:0]  mtime;
    logic [63:0]  mtimecmp;

    // ----------------------------------------
    // Bus front end
    // ----------------------------------------
    timer_bus_slave u_bus_slave (
        .clk      (clk),
        .rst_n    (rst_n),
        .bus_req  (bus_req),
        .mtime    (mtime),
        .mtimecmp (mtimecmp),
        .cfg      (cfg),
        .bus_rsp  (bus_rsp),
        .reg_wr   (reg_wr)
    );

    // ----------------------------------------
    // Time base
    // ----------------------------------------
    timer_prescaler u_prescaler (
        .clk    (clk),
        .rst_n  (rst_n),
        .reg_wr (reg_wr),
        .cfg    (cfg),
        .tick   (tick)
    );

    timer_mtime u_mtime (
        .clk    (clk),
        .rst_n  (rst_n),
        .reg_wr (reg_wr),
        .tick   (tick),
        .mtime  (mtime)
    );

    // Compare and interrupt
    timer_compare u_compare (
        .clk       (clk),
        .rst_n     (rst_n),
        .reg_wr    (reg_wr),
        .mtime     (mtime),
        .mtimecmp  (mtimecmp),
        .timer_irq (timer_irq)
    );

    assign timer_val = mtime;

endmodule

// File: verif/timer_checker.sv
// Bound assertions for the machine timer
// Bus handshake and response timing
// Time counter hold and carry rules
module timer_checker
    import timer_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  bus_rsp_t     bus_rsp,
    input  logic [63:0]  timer_val,
    input  timer_cfg_t   cfg,
    input  reg_wr_t      reg_wr,
    input  logic         tick
);

    // Count of assertion failures
    int unsigned err_cnt = 0;

    // ----------------------------------------
    // Bus handshake
    // ----------------------------------------
    // Ack is a one-cycle pulse
    ack_single: assert property (@(posedge clk) disable iff (!rst_n)
        bus_rsp.req_ack |=> !bus_rsp.req_ack)
    else begin
        err_cnt++;
        $error("req_ack stayed high for two cycles");
    end

    // Response only in the cycle after the ack
    resp_timing: assert property (@(posedge clk) disable iff (!rst_n)
        (bus_rsp.resp != mem_resp_notrdy) == $past(bus_rsp.req_ack))
    else begin
        err_cnt++;
        $error("response not aligned to the accepted request");
    end

    // ----------------------------------------
    // Time counter
    // ----------------------------------------
    hold_when_off: assert property (@(posedge clk) disable iff (!rst_n)
        !cfg.en && !reg_wr.mtime_lo && !reg_wr.mtime_hi |=> $stable(timer_val))
    else begin
        err_cnt++;
        $error("timer_val moved while the timer was disabled");
    end

    // High word moves only on a carry out of the low word
    hi_no_carry: assert property (@(posedge clk) disable iff (!rst_n)
        tick && !(&timer_val[31:0]) |=> $stable(timer_val[63:32]))
    else begin
        err_cnt++;
        $error("high word changed without a carry");
    end

    hi_carry: assert property (@(posedge clk) disable iff (!rst_n)
        tick && (&timer_val[31:0]) |=> timer_val[63:32] == $past(timer_val[63:32]) + 32'd1)
    else begin
        err_cnt++;
        $error("high word missed the carry");
    end

endmodule

// File: verif/timer_tb.sv
// Testbench for the machine timer
// Clock, reset and bus read and write tasks
// Directed tests with per-test report and closing status
module timer_tb
    import timer_pkg::*;
();

    logic         clk = 1'b0;
    logic         rst_n;
    bus_req_t     bus_req;
    bus_rsp_t     bus_rsp;
    logic [63:0]  timer_val;
    logic         timer_irq;

    integer       seed = 32'h7b78f9ac;
    int           test_errs;
    int           tests_run;
    int           tests_failed;

    timer_top u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus_req   (bus_req),
        .bus_rsp   (bus_rsp),
        .timer_val (timer_val),
        .timer_irq (timer_irq)
    );

    bind timer_top timer_checker u_checker (.*);

    always #10 clk = ~clk;

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    task automatic abort_run(input string why);
        $display("ERROR: %s", why);
        $display("STATUS: FAIL");
        $finish;
    endtask

    task automatic check_eq(input string name, input logic [63:0] got,
                            input logic [63:0] exp);
        assert (got === exp) else begin
            $display("FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
            test_errs++;
        end
    endtask

    // One bus transfer with the request held until ack
    task automatic bus_access(input mem_cmd_e cmd, input mem_width_e width,
                              input logic [31:0] addr, input logic [31:0] wdata,
                              output mem_resp_e resp, output logic [31:0] rdata);
        int n;
        @(negedge clk);
        bus_req = '{req: 1'b1, cmd: cmd, width: width, addr: addr, wdata: wdata};
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!bus_rsp.req_ack && n < 8);
        if (!bus_rsp.req_ack) begin
            abort_run("DUT never raised req_ack");
        end else begin
            bus_req = '0;
            n = 0;
            do begin
                @(negedge clk);
                n++;
            end while (bus_rsp.resp == mem_resp_notrdy && n < 8);
            if (bus_rsp.resp == mem_resp_notrdy) begin
                abort_run("DUT never sent a response");
            end else begin
                resp  = bus_rsp.resp;
                rdata = bus_rsp.rdata;
            end
        end
    endtask

    task automatic reg_write(input logic [31:0] offs, input logic [31:0] data);
        mem_resp_e    resp;
        logic [31:0]  rd;
        bus_access(mem_cmd_wr, mem_width_word, offs, data, resp, rd);
        check_eq("bus_rsp.resp", resp, mem_resp_ok);
    endtask

    task automatic reg_read(input logic [31:0] offs, output logic [31:0] data);
        mem_resp_e    resp;
        bus_access(mem_cmd_rd, mem_width_word, offs, 32'h0, resp, data);
        check_eq("bus_rsp.resp", resp, mem_resp_ok);
    endtask

    task automatic read_check(input string name, input logic [31:0] offs,
                              input logic [31:0] exp);
        logic [31:0]  rd;
        reg_read(offs, rd);
        check_eq(name, rd, exp);
    endtask

    // Rejected access gives an error response and zero data
    task automatic expect_error(input mem_cmd_e cmd, input mem_width_e width,
                                input logic [31:0] addr);
        mem_resp_e    resp;
        logic [31:0]  rd;
        bus_access(cmd, width, addr, 32'h0000_015a, resp, rd);
        check_eq("bus_rsp.resp", resp, mem_resp_err);
        check_eq("bus_rsp.rdata", rd, 32'h0);
    endtask

    task automatic end_test(input string name);
        if (test_errs == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, test_errs);
            tests_failed++;
        end
        tests_run++;
        test_errs = 0;
    endtask

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial begin
        logic [31:0]  val;
        logic [63:0]  t0;
        logic [63:0]  t1;
        int           n;
        rst_n        = 1'b0;
        bus_req      = '0;
        test_errs    = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Reset values with irq high since 0 >= 0
        read_check("control", addr_control, 32'h1);
        read_check("divider", addr_divider, 32'h0);
        read_check("mtimecmp_lo", addr_cmp_lo, 32'h0);
        read_check("mtimecmp_hi", addr_cmp_hi, 32'h0);
        check_eq("timer_irq", timer_irq, 1'b1);
        end_test("reset_state");

        val = $random(seed);
        reg_write(addr_divider, val);
        read_check("divider", addr_divider, val & 32'h3ff);
        val = $random(seed);
        reg_write(addr_cmp_lo, val);
        read_check("mtimecmp_lo", addr_cmp_lo, val);
        val = $random(seed);
        reg_write(addr_cmp_hi, val);
        read_check("mtimecmp_hi", addr_cmp_hi, val);
        // Only the enable bit exists
        reg_write(addr_control, 32'hffff_ffff);
        read_check("control", addr_control, 32'h1);
        end_test("write_readback");

        // One tick every 4 cycles
        reg_write(addr_divider, 32'd3);
        t0 = timer_val;
        repeat (40) @(negedge clk);
        t1 = timer_val;
        assert ((t1 - t0) >= 64'd9 && (t1 - t0) <= 64'd11) else begin
            $display("FAILED timer_val delta 0x%0h expected 0x9 to 0xb", t1 - t0);
            test_errs++;
        end
        end_test("prescaler_rate");

        reg_write(addr_control, 32'h0);
        reg_write(addr_mtime_lo, 32'hffff_fffe);
        reg_write(addr_mtime_hi, 32'h5);
        reg_write(addr_divider, 32'h0);
        reg_write(addr_control, 32'h1);
        n = 0;
        while (timer_val[63:32] != 32'h6 && n < 10) begin
            @(negedge clk);
            n++;
        end
        check_eq("timer_val[63:32]", timer_val[63:32], 32'h6);
        assert (timer_val[31:0] < 32'd10) else begin
            $display("FAILED timer_val[31:0] 0x%0h not below 0xa", timer_val[31:0]);
            test_errs++;
        end
        read_check("mtime_hi", addr_mtime_hi, 32'h6);
        end_test("carry_high_word");

        reg_write(addr_cmp_hi, 32'hffff_ffff);
        check_eq("timer_irq", timer_irq, 1'b0);
        t0 = timer_val + 64'd50;
        reg_write(addr_cmp_lo, t0[31:0]);
        reg_write(addr_cmp_hi, t0[63:32]);
        repeat (20) begin
            @(negedge clk);
            check_eq("timer_irq", timer_irq, 1'b0);
        end
        n = 0;
        while (!timer_irq && n < 100) begin
            @(negedge clk);
            n++;
        end
        check_eq("timer_irq", timer_irq, 1'b1);
        // Level stays set with no compare write
        repeat (20) begin
            @(negedge clk);
            check_eq("timer_irq", timer_irq, 1'b1);
        end
        end_test("interrupt");

        reg_read(addr_divider, val);
        reg_read(addr_cmp_lo, t0[31:0]);
        reg_read(addr_cmp_hi, t0[63:32]);
        expect_error(mem_cmd_wr, mem_width_byte, 32'(addr_cmp_lo));
        expect_error(mem_cmd_wr, mem_width_byte, 32'(addr_cmp_hi));
        expect_error(mem_cmd_wr, mem_width_half, 32'(addr_divider));
        expect_error(mem_cmd_rd, mem_width_word, 32'h0000_0006);
        expect_error(mem_cmd_wr, mem_width_word, 32'h0000_0018);
        read_check("divider", addr_divider, val);
        read_check("mtimecmp_lo", addr_cmp_lo, t0[31:0]);
        read_check("mtimecmp_hi", addr_cmp_hi, t0[63:32]);
        end_test("invalid_access");

        $display("tests %0d, failed %0d, assertion errors %0d",
                 tests_run, tests_failed, u_dut.u_checker.err_cnt);
        if (tests_failed == 0 && u_dut.u_checker.err_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: verilog.f
verilog/timer_pkg.sv
verilog/timer_bus_slave.sv
verilog/timer_prescaler.sv
verilog/timer_mtime.sv
verilog/timer_compare.sv
verilog/timer_top.sv
verif/timer_checker.sv
verif/timer_tb.sv

// File: Bender.yml
package:
  name: timer

sources:
  - files:
      - verilog/timer_pkg.sv
      - verilog/timer_bus_slave.sv
      - verilog/timer_prescaler.sv
      - verilog/timer_mtime.sv
      - verilog/timer_compare.sv
      - verilog/timer_top.sv
  - target: test
    files:
      - verif/timer_checker.sv
      - verif/timer_tb.sv
